//--- Makefile
TOP = cpuDatapathTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- design/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  wire logic                            Clock,
    input  wire logic                            arstN,
    input  wire cpuBusPkg::ctrlWord_t            ctrl,
    input  wire logic [cpuIsaPkg::dataWidth-1:0] rbValue,
    input  wire logic                            zeroRb,
    input  wire logic [cpuIsaPkg::dataWidth-1:0] rcValue,
    input  wire logic [cpuIsaPkg::dataWidth-1:0] immValue,
    output logic [cpuIsaPkg::dataWidth-1:0]      zValue
);

    cpuBusPkg::operands_t            operands;
    logic [cpuIsaPkg::dataWidth-1:0] yValue;
    logic [cpuIsaPkg::dataWidth-1:0] aluOut;

    // Operand paths from the register file and the immediate decode
    assign operands.rbValue = zeroRb ? '0 : rbValue;
    assign operands.secondValue = ctrl.immOut ? immValue : rcValue;

    // Y holds the base operand
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            yValue <= '0;
        end else if (ctrl.yEnable) begin
            yValue <= operands.rbValue;
        end
    end

    // Y combined with the second operand, wraps at data width
    always_comb begin
        case (ctrl.aluOp)
            cpuIsaPkg::opAdd,
            cpuIsaPkg::opAddi: aluOut = yValue + operands.secondValue;
            cpuIsaPkg::opSub:  aluOut = yValue - operands.secondValue;
            cpuIsaPkg::opAnd,
            cpuIsaPkg::opAndi: aluOut = yValue & operands.secondValue;
            cpuIsaPkg::opOr,
            cpuIsaPkg::opOri:  aluOut = yValue | operands.secondValue;
            default:           aluOut = yValue + operands.secondValue;
        endcase
    end

    // Z captures the ALU result
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            zValue <= '0;
        end else if (ctrl.zEnable) begin
            zValue <= aluOut;
        end
    end

endmodule

`default_nettype wire

//--- design/controlSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module controlSequencer (
    input  wire logic                            Clock,
    input  wire logic                            arstN,
    input  wire logic                            instrValid,
    input  wire cpuIsaPkg::instr_t               instr,
    input  wire logic                            resultReady,
    input  wire logic [cpuIsaPkg::dataWidth-1:0] zValue,
    output logic                                 instrReady,
    output logic                                 resultValid,
    output cpuBusPkg::result_t                   result,
    output cpuIsaPkg::instr_t                    ir,
    output cpuBusPkg::ctrlWord_t                 ctrl
);

    cpuBusPkg::step_e   step;
    cpuBusPkg::step_e   stepNext;
    cpuIsaPkg::opcode_e decodedOp;
    logic               illegal;
    logic               isImm;

    // Opcode decode
    always_comb begin
        decodedOp = cpuIsaPkg::opAdd;
        illegal = 1'b0;
        isImm = 1'b0;
        case (ir.opcode)
            cpuIsaPkg::opAdd:  decodedOp = cpuIsaPkg::opAdd;
            cpuIsaPkg::opSub:  decodedOp = cpuIsaPkg::opSub;
            cpuIsaPkg::opAnd:  decodedOp = cpuIsaPkg::opAnd;
            cpuIsaPkg::opOr:   decodedOp = cpuIsaPkg::opOr;
            cpuIsaPkg::opAddi: begin
                decodedOp = cpuIsaPkg::opAddi;
                isImm = 1'b1;
            end
            cpuIsaPkg::opAndi: begin
                decodedOp = cpuIsaPkg::opAndi;
                isImm = 1'b1;
            end
            cpuIsaPkg::opOri:  begin
                decodedOp = cpuIsaPkg::opOri;
                isImm = 1'b1;
            end
            // Unknown code still walks the steps but never writes
            default: illegal = 1'b1;
        endcase
    end

    // Step sequencing
    always_comb begin
        stepNext = step;
        case (step)
            cpuBusPkg::stepIdle: begin
                if (instrValid) begin
                    stepNext = cpuBusPkg::stepFetch;
                end
            end
            cpuBusPkg::stepFetch:  stepNext = cpuBusPkg::stepLoadY;
            cpuBusPkg::stepLoadY:  stepNext = cpuBusPkg::stepLoadZ;
            cpuBusPkg::stepLoadZ:  stepNext = cpuBusPkg::stepWriteBack;
            cpuBusPkg::stepWriteBack: begin
                // Hold until the result is taken
                if (resultReady) begin
                    stepNext = cpuBusPkg::stepIdle;
                end
            end
            default: stepNext = cpuBusPkg::stepIdle;
        endcase
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            step <= cpuBusPkg::stepIdle;
        end else begin
            step <= stepNext;
        end
    end

    // Handshake levels follow the step
    assign instrReady = (step == cpuBusPkg::stepIdle);
    assign resultValid = (step == cpuBusPkg::stepWriteBack);

    // Control word for the current step
    always_comb begin
        ctrl = '0;
        ctrl.aluOp = decodedOp;
        case (step)
            cpuBusPkg::stepIdle: begin
                // IR loads on the accepting edge
                ctrl.irEnable = instrValid;
            end
            cpuBusPkg::stepLoadY: begin
                ctrl.yEnable = 1'b1;
                // Immediate forms read Rb as a base address
                ctrl.baOut = isImm;
            end
            cpuBusPkg::stepLoadZ: begin
                ctrl.zEnable = 1'b1;
                ctrl.immOut = isImm;
            end
            cpuBusPkg::stepWriteBack: begin
                // Write only on the transfer edge
                ctrl.regWrite = resultReady && !illegal;
            end
            default: ctrl.irEnable = 1'b0;
        endcase
    end

    // Instruction register
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            ir <= '0;
        end else if (ctrl.irEnable) begin
            ir <= instr;
        end
    end

    // Result taken straight from Z and the Ra field
    assign result.destIdx = ir.ra;
    assign result.value = zValue;
    assign result.illegal = illegal;

    // One instruction in flight at a time
    // Ready comes back only on the edge after a result transfer
    assert property (@(posedge Clock) disable iff (!arstN)
        $rose(instrReady) |-> $past(resultValid && resultReady));

    // Result held under back-pressure
    assert property (@(posedge Clock) disable iff (!arstN)
        (resultValid && !resultReady) |=> $stable(result));

endmodule

`default_nettype wire

//--- design/cpuBusPkg.sv
`default_nettype none

// Control and data records passed between the datapath blocks
package cpuBusPkg;

    // Sequenced control steps of one instruction
    typedef enum logic [2:0] {
        stepIdle      = 3'd0,
        stepFetch     = 3'd1,
        stepLoadY     = 3'd2,
        stepLoadZ     = 3'd3,
        stepWriteBack = 3'd4
    } step_e;

    // Control signals for one cycle
    typedef struct packed {
        // Instruction register load
        logic              irEnable;
        // Y and Z register loads
        logic              yEnable;
        logic              zEnable;
        // Base-address read, Rb index 0 reads as zero
        logic              baOut;
        // Second operand from the immediate instead of Rc
        logic              immOut;
        // Operation applied when Z loads
        cpuIsaPkg::opcode_e aluOp;
        // Register file write strobe
        logic              regWrite;
    } ctrlWord_t;

    // The two ALU operands after selection
    typedef struct packed {
        logic [cpuIsaPkg::dataWidth-1:0] rbValue;
        logic [cpuIsaPkg::dataWidth-1:0] secondValue;
    } operands_t;

    // Writeback report
    typedef struct packed {
        logic [cpuIsaPkg::regIdxWidth-1:0] destIdx;
        logic [cpuIsaPkg::dataWidth-1:0]   value;
        // Opcode not in the supported list
        logic                              illegal;
    } result_t;

endpackage

`default_nettype wire

//--- design/cpuDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module cpuDatapath (
    input  wire logic               Clock,
    input  wire logic               arstN,
    // Instruction port
    input  wire logic               instrValid,
    output logic                    instrReady,
    input  wire cpuIsaPkg::instr_t  instr,
    // Result port
    output logic                    resultValid,
    input  wire logic               resultReady,
    output cpuBusPkg::result_t      result
);

    cpuBusPkg::ctrlWord_t              ctrl;
    cpuIsaPkg::instr_t                 ir;
    logic [cpuIsaPkg::regIdxWidth-1:0] rbIdx;
    logic [cpuIsaPkg::regIdxWidth-1:0] rcIdx;
    logic [cpuIsaPkg::regIdxWidth-1:0] raIdx;
    logic [cpuIsaPkg::dataWidth-1:0]   immValue;
    logic                              zeroRb;
    logic [cpuIsaPkg::dataWidth-1:0]   rbValue;
    logic [cpuIsaPkg::dataWidth-1:0]   rcValue;
    logic [cpuIsaPkg::dataWidth-1:0]   zValue;

    // Steps, IR and handshakes
    controlSequencer uSequencer (
        .Clock       (Clock),
        .arstN       (arstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .resultReady (resultReady),
        .zValue      (zValue),
        .instrReady  (instrReady),
        .resultValid (resultValid),
        .result      (result),
        .ir          (ir),
        .ctrl        (ctrl)
    );

    // IR field decode
    operandSelect uOperandSelect (
        .ir       (ir),
        .ctrl     (ctrl),
        .rbIdx    (rbIdx),
        .rcIdx    (rcIdx),
        .raIdx    (raIdx),
        .immValue (immValue),
        .zeroRb   (zeroRb)
    );

    // Writeback goes to Ra on the transfer edge
    registerFile uRegisterFile (
        .Clock       (Clock),
        .arstN       (arstN),
        .rbIdx       (rbIdx),
        .rcIdx       (rcIdx),
        .writeIdx    (raIdx),
        .writeEnable (ctrl.regWrite),
        .writeValue  (zValue),
        .rbValue     (rbValue),
        .rcValue     (rcValue)
    );

    aluUnit uAlu (
        .Clock    (Clock),
        .arstN    (arstN),
        .ctrl     (ctrl),
        .rbValue  (rbValue),
        .zeroRb   (zeroRb),
        .rcValue  (rcValue),
        .immValue (immValue),
        .zValue   (zValue)
    );

endmodule

`default_nettype wire

//--- design/cpuIsaPkg.sv
`default_nettype none

// Instruction set view of the datapath
package cpuIsaPkg;

    // Register and data width
    localparam int dataWidth = 32;

    // General register file size
    localparam int regCount = 16;
    localparam int regIdxWidth = 4;

    // Constant field of the immediate forms
    localparam int immWidth = 19;

    // Opcode field width
    localparam int opcodeWidth = 5;

    // Supported opcodes, register and immediate ALU forms
    typedef enum logic [opcodeWidth-1:0] {
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b00101,
        opOr   = 5'b00110,
        opAddi = 5'b01100,
        opAndi = 5'b01101,
        opOri  = 5'b01110
    } opcode_e;

    // 32-bit instruction word
    // Opcode kept as raw bits so unknown codes can reach the decoder
    // Rc sits in the top four bits of the constant field
    typedef struct packed {
        logic [opcodeWidth-1:0] opcode;
        logic [regIdxWidth-1:0] ra;
        logic [regIdxWidth-1:0] rb;
        logic [immWidth-1:0]    c;
    } instr_t;

endpackage

`default_nettype wire

//--- design/operandSelect.sv
`timescale 1ns/1ps
`default_nettype none

module operandSelect (
    input  wire cpuIsaPkg::instr_t               ir,
    input  wire cpuBusPkg::ctrlWord_t            ctrl,
    output logic [cpuIsaPkg::regIdxWidth-1:0]    rbIdx,
    output logic [cpuIsaPkg::regIdxWidth-1:0]    rcIdx,
    output logic [cpuIsaPkg::regIdxWidth-1:0]    raIdx,
    output logic [cpuIsaPkg::dataWidth-1:0]      immValue,
    output logic                                 zeroRb
);

    // Sign bit of the constant field
    logic immSign;

    // Register fields straight from the IR
    assign raIdx = ir.ra;
    assign rbIdx = ir.rb;

    // Rc overlaps the top of the constant field
    assign rcIdx = ir.c[cpuIsaPkg::immWidth-1 -: cpuIsaPkg::regIdxWidth];

    // Sign-extend the 19-bit constant to data width
    assign immSign = ir.c[cpuIsaPkg::immWidth-1];
    assign immValue = {{(cpuIsaPkg::dataWidth - cpuIsaPkg::immWidth){immSign}}, ir.c};

    // Base-address read, Rb index 0 supplies zero instead of R0
    assign zeroRb = ctrl.baOut && (ir.rb == '0);

endmodule

`default_nettype wire

//--- design/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  wire logic                              Clock,
    input  wire logic                              arstN,
    input  wire logic [cpuIsaPkg::regIdxWidth-1:0] rbIdx,
    input  wire logic [cpuIsaPkg::regIdxWidth-1:0] rcIdx,
    input  wire logic [cpuIsaPkg::regIdxWidth-1:0] writeIdx,
    input  wire logic                              writeEnable,
    input  wire logic [cpuIsaPkg::dataWidth-1:0]   writeValue,
    output logic [cpuIsaPkg::dataWidth-1:0]        rbValue,
    output logic [cpuIsaPkg::dataWidth-1:0]        rcValue
);

    // General registers R0..R15
    logic [cpuIsaPkg::dataWidth-1:0] regs [cpuIsaPkg::regCount];

    // Single write port
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < cpuIsaPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeIdx] <= writeValue;
        end
    end

    // Two combinational read ports
    // R0 is an ordinary register here, base-address zero is applied upstream
    assign rbValue = regs[rbIdx];
    assign rcValue = regs[rcIdx];

    // A write must name a known register
    assert property (@(posedge Clock) disable iff (!arstN)
        writeEnable |-> !$isunknown(writeIdx));

endmodule

`default_nettype wire

//--- dv/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic Clock
);

    // Half of the 4 ns period
    localparam int halfPeriod = 2;

    initial begin
        Clock = 1'b0;
    end

    always #halfPeriod Clock = ~Clock;

endmodule

`default_nettype wire

//--- dv/cpuDatapathTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuDatapathTb;

    // Accepting cycle counts as the first, writeBack is the fourth
    localparam int resultLatency = 4;
    // Bound for every wait loop, in cycles
    localparam int waitLimit = 50;
    localparam int randomCount = 200;

    logic                 Clock;
    logic                 arstN;
    logic                 instrValid;
    logic                 instrReady;
    cpuIsaPkg::instr_t    instr;
    logic                 resultValid;
    logic                 resultReady;
    cpuBusPkg::result_t   result;

    integer               seed;
    int                   legalCount;
    // Reference copy of R0..R15
    logic [31:0]          modelRegs [cpuIsaPkg::regCount];

    clockGen uClock (
        .Clock (Clock)
    );

    cpuDatapath uut (
        .Clock       (Clock),
        .arstN       (arstN),
        .instrValid  (instrValid),
        .instrReady  (instrReady),
        .instr       (instr),
        .resultValid (resultValid),
        .resultReady (resultReady),
        .result      (result)
    );

    task automatic stopRun(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    // Writeback report against the model
    task automatic compareResult(input cpuBusPkg::result_t expected, input bit checkValue);
        if (result.destIdx !== expected.destIdx) begin
            stopRun($sformatf("[ERROR] %0t result.destIdx expected %0d actual %0d",
                $time, expected.destIdx, result.destIdx));
        end
        if (result.illegal !== expected.illegal) begin
            stopRun($sformatf("[ERROR] %0t result.illegal expected %b actual %b",
                $time, expected.illegal, result.illegal));
        end
        if (checkValue && (result.value !== expected.value)) begin
            stopRun($sformatf("[ERROR] %0t result.value expected %h actual %h",
                $time, expected.value, result.value));
        end
    endtask

    // Handshake levels
    task automatic compareReady(input logic expReady, input logic expValid);
        if (instrReady !== expReady) begin
            stopRun($sformatf("[ERROR] %0t instrReady expected %b actual %b",
                $time, expReady, instrReady));
        end
        if (resultValid !== expValid) begin
            stopRun($sformatf("[ERROR] %0t resultValid expected %b actual %b",
                $time, expValid, resultValid));
        end
    endtask

    function automatic logic isLegal(input logic [4:0] opcode);
        case (opcode)
            5'b00011, 5'b00100, 5'b00101, 5'b00110,
            5'b01100, 5'b01101, 5'b01110: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Expected result from the model registers
    function automatic cpuBusPkg::result_t predictResult(input cpuIsaPkg::instr_t word);
        cpuBusPkg::result_t expected;
        logic [31:0]        base;
        logic [31:0]        second;
        logic               immForm;
        immForm = (word.opcode[4:2] == 3'b011);
        // Immediate forms treat Rb index 0 as a zero base
        base = (immForm && (word.rb == 4'd0)) ? 32'd0 : modelRegs[word.rb];
        second = immForm ? {{13{word.c[18]}}, word.c} : modelRegs[word.c[18:15]];
        expected.destIdx = word.ra;
        expected.illegal = !isLegal(word.opcode);
        case (word.opcode)
            5'b00011, 5'b01100: expected.value = base + second;
            5'b00100:           expected.value = base - second;
            5'b00101, 5'b01101: expected.value = base & second;
            5'b00110, 5'b01110: expected.value = base | second;
            default:            expected.value = '0;
        endcase
        return expected;
    endfunction

    function automatic cpuIsaPkg::instr_t randomLegal();
        cpuIsaPkg::instr_t word;
        int                pick;
        pick = int'($unsigned($random(seed)) % 7);
        case (pick)
            0: word.opcode = cpuIsaPkg::opAdd;
            1: word.opcode = cpuIsaPkg::opSub;
            2: word.opcode = cpuIsaPkg::opAnd;
            3: word.opcode = cpuIsaPkg::opOr;
            4: word.opcode = cpuIsaPkg::opAddi;
            5: word.opcode = cpuIsaPkg::opAndi;
            default: word.opcode = cpuIsaPkg::opOri;
        endcase
        word.ra = 4'($random(seed));
        word.rb = 4'($random(seed));
        word.c = 19'($random(seed));
        return word;
    endfunction

    function automatic cpuIsaPkg::instr_t randomIllegal();
        cpuIsaPkg::instr_t word;
        word = randomLegal();
        // Redraw until the code falls outside the supported list
        do begin
            word.opcode = 5'($random(seed));
        end while (isLegal(word.opcode));
        return word;
    endfunction

    // One instruction from offer to transfer, with latency and back-pressure checks
    task automatic executeInstr(input cpuIsaPkg::instr_t word);
        cpuBusPkg::result_t expected;
        int                 cycles;
        int                 waited;
        expected = predictResult(word);
        @(posedge Clock);
        instrValid <= 1'b1;
        instr <= word;
        resultReady <= 1'($random(seed));
        waited = 0;
        @(negedge Clock);
        while (!instrReady) begin
            waited++;
            if (waited > waitLimit) begin
                stopRun("Timeout waiting for instrReady");
            end
            @(negedge Clock);
        end
        // Accepting edge
        @(posedge Clock);
        instrValid <= 1'b0;
        cycles = 1;
        @(negedge Clock);
        while (!resultValid) begin
            compareReady(1'b0, 1'b0);
            if (cycles >= waitLimit) begin
                stopRun("Timeout waiting for resultValid");
            end
            @(posedge Clock);
            cycles++;
            @(negedge Clock);
        end
        if (cycles != resultLatency) begin
            stopRun($sformatf("[ERROR] %0t resultLatency expected %0d actual %0d",
                $time, resultLatency, cycles));
        end
        compareReady(1'b0, 1'b1);
        compareResult(expected, !expected.illegal);
        // Random back-pressure, result must hold
        waited = 0;
        while (!resultReady) begin
            waited++;
            if (waited > waitLimit) begin
                stopRun("Timeout waiting for the result transfer");
            end
            @(posedge Clock);
            resultReady <= 1'($random(seed));
            @(negedge Clock);
            compareReady(1'b0, 1'b1);
            compareResult(expected, !expected.illegal);
        end
        // Transfer edge, the only write of this instruction
        @(posedge Clock);
        resultReady <= 1'b0;
        if (!expected.illegal) begin
            modelRegs[expected.destIdx] = expected.value;
        end
        @(negedge Clock);
        compareReady(1'b1, 1'b0);
    endtask

    initial begin
        cpuIsaPkg::instr_t word;
        seed = 53;
        arstN = 1'b0;
        instrValid = 1'b0;
        instr = '0;
        resultReady = 1'b0;
        for (int r = 0; r < cpuIsaPkg::regCount; r++) begin
            modelRegs[r] = '0;
        end
        repeat (3) @(posedge Clock);
        arstN <= 1'b1;
        @(negedge Clock);
        compareReady(1'b1, 1'b0);

        // Fill R1..R15 with addi from R0, odd registers get negative constants
        for (int r = 1; r < cpuIsaPkg::regCount; r++) begin
            word.opcode = cpuIsaPkg::opAddi;
            word.ra = 4'(r);
            word.rb = 4'd0;
            word.c = 19'($random(seed));
            word.c[18] = r[0];
            executeInstr(word);
        end

        // Random legal mix with illegal codes sprinkled in
        legalCount = 0;
        while (legalCount < randomCount) begin
            if (($random(seed) & 7) == 0) begin
                executeInstr(randomIllegal());
            end else begin
                executeInstr(randomLegal());
                legalCount++;
            end
        end

        // Self-increment chain, each step reads the previous write
        for (int k = 0; k < 4; k++) begin
            word.opcode = cpuIsaPkg::opAddi;
            word.ra = 4'd5;
            word.rb = 4'd5;
            word.c = 19'd1;
            executeInstr(word);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
design/cpuIsaPkg.sv
design/cpuBusPkg.sv
design/controlSequencer.sv
design/registerFile.sv
design/operandSelect.sv
design/aluUnit.sv
design/cpuDatapath.sv
dv/clockGen.sv
dv/cpuDatapathTb.sv
